// ==== hdl/axil_mem_defs.svh ====
`ifndef AXIL_MEM_DEFS_SVH
`define AXIL_MEM_DEFS_SVH

// AXI4-Lite data path, one 32-bit word
`define AXIL_DATA_W 32

// Byte address width
`define AXIL_ADDR_W 32

// One strobe lane per data byte
`define AXIL_STRB_W 4

// Requester and domain ID widths
`define LCE_ID_W 4
`define DID_W 3

// Target depth in 32-bit words, addresses wrap modulo this
`define MEM_WORDS 64

`endif

// ==== hdl/axil_mem_pkg.sv ====
`default_nettype none

`include "axil_mem_defs.svh"

package axil_mem_pkg;

  // Uncached message types
  typedef enum logic {
    e_uc_rd = 1'b0,
    e_uc_wr = 1'b1
  } msg_type_e;

  // Log2 of the access size in bytes
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2
  } msg_size_e;

  // Request header on the forward channel
  typedef struct packed {
    msg_type_e               msg_type;
    msg_size_e               size;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`LCE_ID_W-1:0]    lce_id;
    logic [`DID_W-1:0]       did;
  } mem_fwd_header_s;

  // Response header, fields echoed from the request
  typedef struct packed {
    msg_type_e               msg_type;
    msg_size_e               size;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`LCE_ID_W-1:0]    lce_id;
    logic [`DID_W-1:0]       did;
  } mem_rev_header_s;

endpackage

`default_nettype wire

// ==== hdl/mem_msg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_defs.svh"

// One message channel, header plus one data word
interface mem_msg_if #(
  parameter type header_t = logic
) ();

  header_t                 header;
  logic [`AXIL_DATA_W-1:0] data;
  logic                    v;
  logic                    ready_and;

  // Transfer on a rising edge with v and ready_and both high
  modport sender (
    output header,
    output data,
    output v,
    input  ready_and
  );

  modport receiver (
    input  header,
    input  data,
    input  v,
    output ready_and
  );

endinterface

`default_nettype wire

// ==== hdl/axil_fifo_client.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_defs.svh"

module axil_fifo_client (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  // AXI4-Lite client side
  input  wire [`AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  wire                      s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  wire [`AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  wire [`AXIL_STRB_W-1:0]   s_axil_wstrb_i,
  input  wire                      s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  wire                      s_axil_bready_i,
  input  wire [`AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  wire                      s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic [`AXIL_DATA_W-1:0]  s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  wire                      s_axil_rready_i,
  // Request toward the memory client
  output logic [`AXIL_DATA_W-1:0]  data_o,
  output logic [`AXIL_ADDR_W-1:0]  addr_o,
  output logic                     v_o,
  output logic                     w_o,
  output logic [`AXIL_STRB_W-1:0]  wmask_o,
  input  wire                      ready_and_i,
  // Response from the memory client
  input  wire [`AXIL_DATA_W-1:0]   data_i,
  input  wire                      v_i,
  output logic                     ready_and_o
);

  typedef enum logic [1:0] {
    e_idle,
    e_req,
    e_wait,
    e_resp
  } state_e;

  state_e                  state_q;
  logic                    wr_accept;
  logic                    rd_accept;
  logic                    resp_done;
  logic [`AXIL_DATA_W-1:0] wdata_q;
  logic [`AXIL_ADDR_W-1:0] addr_q;
  logic [`AXIL_STRB_W-1:0] wmask_q;
  logic                    w_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;

  // Write wins over a read offered in the same cycle
  assign wr_accept = (state_q == e_idle) && s_axil_awvalid_i && s_axil_wvalid_i;
  assign rd_accept = (state_q == e_idle) && s_axil_arvalid_i
                     && !s_axil_awvalid_i && !s_axil_wvalid_i;
  assign resp_done = w_q ? s_axil_bready_i : s_axil_rready_i;

  assign s_axil_awready_o = wr_accept;
  assign s_axil_wready_o  = wr_accept;
  assign s_axil_arready_o = rd_accept;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= e_idle;
    end else begin
      case (state_q)
        e_idle:  if (wr_accept || rd_accept) state_q <= e_req;
        e_req:   if (ready_and_i) state_q <= e_wait;
        e_wait:  if (v_i) state_q <= e_resp;
        default: if (resp_done) state_q <= e_idle;
      endcase
    end
  end

  // Latched transaction and returned read data
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      addr_q  <= s_axil_awaddr_i;
      wdata_q <= s_axil_wdata_i;
      wmask_q <= s_axil_wstrb_i;
      w_q     <= 1'b1;
    end else if (rd_accept) begin
      addr_q  <= s_axil_araddr_i;
      wmask_q <= '0;
      w_q     <= 1'b0;
    end
    if ((state_q == e_wait) && v_i) begin
      rdata_q <= data_i;
    end
  end

  assign data_o      = wdata_q;
  assign addr_o      = addr_q;
  assign w_o         = w_q;
  assign wmask_o     = wmask_q;
  assign v_o         = (state_q == e_req);
  assign ready_and_o = (state_q == e_wait);

  // Responses are always OKAY
  assign s_axil_bresp_o  = 2'b00;
  assign s_axil_rresp_o  = 2'b00;
  assign s_axil_bvalid_o = (state_q == e_resp) && w_q;
  assign s_axil_rvalid_o = (state_q == e_resp) && !w_q;
  assign s_axil_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/axil_mem_client.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_defs.svh"

module axil_mem_client (
  input  wire [`LCE_ID_W-1:0]     lce_id_i,
  input  wire [`DID_W-1:0]        did_i,
  // Request from the AXI client
  input  wire [`AXIL_DATA_W-1:0]  data_i,
  input  wire [`AXIL_ADDR_W-1:0]  addr_i,
  input  wire                     v_i,
  input  wire                     w_i,
  input  wire [`AXIL_STRB_W-1:0]  wmask_i,
  output logic                    ready_and_o,
  // Response back to the AXI client
  output logic [`AXIL_DATA_W-1:0] data_o,
  output logic                    v_o,
  input  wire                     ready_and_i,
  // Message channels
  mem_msg_if.sender               mem_fwd,
  mem_msg_if.receiver             mem_rev
);

  axil_mem_pkg::mem_fwd_header_s fwd_header;

  always_comb begin
    fwd_header        = '0;
    fwd_header.lce_id = lce_id_i;
    fwd_header.did    = did_i;
    fwd_header.addr   = addr_i;
    fwd_header.msg_type = w_i ? axil_mem_pkg::e_uc_wr : axil_mem_pkg::e_uc_rd;
    if (!w_i) begin
      // Reads fetch the full word
      fwd_header.size = axil_mem_pkg::e_size_4;
    end else begin
      case (wmask_i)
        4'h1, 4'h2, 4'h4, 4'h8: fwd_header.size = axil_mem_pkg::e_size_1;
        4'h3, 4'hC:             fwd_header.size = axil_mem_pkg::e_size_2;
        // Odd patterns fall back to a full word write
        default:                fwd_header.size = axil_mem_pkg::e_size_4;
      endcase
    end
  end

  // Forward path
  assign mem_fwd.header = fwd_header;
  assign mem_fwd.data   = data_i;
  assign mem_fwd.v      = v_i;
  assign ready_and_o    = mem_fwd.ready_and;

  // Reverse path
  assign data_o            = mem_rev.data;
  assign v_o               = mem_rev.v;
  assign mem_rev.ready_and = ready_and_i;

endmodule

`default_nettype wire

// ==== hdl/uc_mem_target.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_defs.svh"

module uc_mem_target (
  input  wire         clk_i,
  input  wire         arst_n_i,
  mem_msg_if.receiver mem_fwd,
  mem_msg_if.sender   mem_rev
);

  localparam int IDX_W = $clog2(`MEM_WORDS);

  axil_mem_pkg::mem_fwd_header_s fwd_header;
  axil_mem_pkg::mem_rev_header_s rev_header_q;

  // Word storage split into byte lanes
  logic [`AXIL_STRB_W-1:0][7:0] mem_q [`MEM_WORDS];
  logic [`AXIL_DATA_W-1:0]      rdata_q;
  logic                         rev_v_q;
  logic                         fwd_xfer;
  logic [IDX_W-1:0]             word_idx;
  logic [1:0]                   lane;
  logic [`AXIL_STRB_W-1:0]      lane_mask;

  assign fwd_header = mem_fwd.header;
  assign fwd_xfer   = mem_fwd.v && mem_fwd.ready_and;
  // Upper address bits beyond the depth are dropped
  assign word_idx   = fwd_header.addr[2 +: IDX_W];
  assign lane       = fwd_header.addr[1:0];

  // Lanes written, 2^size bytes from the addressed lane
  always_comb begin
    case (fwd_header.size)
      axil_mem_pkg::e_size_1: lane_mask = 4'b0001 << lane;
      axil_mem_pkg::e_size_2: lane_mask = 4'b0011 << lane;
      default:                lane_mask = 4'b1111;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (fwd_xfer && (fwd_header.msg_type == axil_mem_pkg::e_uc_wr)) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (lane_mask[b]) begin
          mem_q[word_idx][b] <= mem_fwd.data[8*b +: 8];
        end
      end
    end
  end

  // Response payload, the aligned word and the echoed header
  always_ff @(posedge clk_i) begin
    if (fwd_xfer) begin
      rdata_q               <= mem_q[word_idx];
      rev_header_q.msg_type <= fwd_header.msg_type;
      rev_header_q.size     <= fwd_header.size;
      rev_header_q.addr     <= fwd_header.addr;
      rev_header_q.lce_id   <= fwd_header.lce_id;
      rev_header_q.did      <= fwd_header.did;
    end
  end

  // One response held at a time
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rev_v_q <= 1'b0;
    end else if (fwd_xfer) begin
      rev_v_q <= 1'b1;
    end else if (mem_rev.ready_and) begin
      rev_v_q <= 1'b0;
    end
  end

  assign mem_fwd.ready_and = !rev_v_q;
  assign mem_rev.v         = rev_v_q;
  assign mem_rev.header    = rev_header_q;
  assign mem_rev.data      = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/axil_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_defs.svh"

module axil_mem_top (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  wire [`LCE_ID_W-1:0]      lce_id_i,
  input  wire [`DID_W-1:0]         did_i,
  input  wire [`AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  wire                      s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  wire [`AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  wire [`AXIL_STRB_W-1:0]   s_axil_wstrb_i,
  input  wire                      s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  wire                      s_axil_bready_i,
  input  wire [`AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  wire                      s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic [`AXIL_DATA_W-1:0]  s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  wire                      s_axil_rready_i
);

  // Request and response between the AXI client and the header builder
  logic [`AXIL_DATA_W-1:0] req_data;
  logic [`AXIL_ADDR_W-1:0] req_addr;
  logic                    req_v;
  logic                    req_w;
  logic [`AXIL_STRB_W-1:0] req_wmask;
  logic                    req_ready_and;
  logic [`AXIL_DATA_W-1:0] resp_data;
  logic                    resp_v;
  logic                    resp_ready_and;

  mem_msg_if #(.header_t(axil_mem_pkg::mem_fwd_header_s)) fwd_if ();
  mem_msg_if #(.header_t(axil_mem_pkg::mem_rev_header_s)) rev_if ();

  axil_fifo_client u_fifo_client (
    .clk_i,
    .arst_n_i,
    .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
    .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .data_o      (req_data),
    .addr_o      (req_addr),
    .v_o         (req_v),
    .w_o         (req_w),
    .wmask_o     (req_wmask),
    .ready_and_i (req_ready_and),
    .data_i      (resp_data),
    .v_i         (resp_v),
    .ready_and_o (resp_ready_and)
  );

  axil_mem_client u_mem_client (
    .lce_id_i,
    .did_i,
    .data_i      (req_data),
    .addr_i      (req_addr),
    .v_i         (req_v),
    .w_i         (req_w),
    .wmask_i     (req_wmask),
    .ready_and_o (req_ready_and),
    .data_o      (resp_data),
    .v_o         (resp_v),
    .ready_and_i (resp_ready_and),
    .mem_fwd     (fwd_if.sender),
    .mem_rev     (rev_if.receiver)
  );

  uc_mem_target u_mem_target (
    .clk_i,
    .arst_n_i,
    .mem_fwd (fwd_if.receiver),
    .mem_rev (rev_if.sender)
  );

endmodule

`default_nettype wire

// ==== verif/axil_mem_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_defs.svh"

module axil_mem_sva (
  input wire                                clk_i,
  input wire                                arst_n_i,
  input wire                                awvalid_i,
  input wire                                awready_i,
  input wire [`AXIL_ADDR_W-1:0]             awaddr_i,
  input wire                                wvalid_i,
  input wire                                wready_i,
  input wire [`AXIL_DATA_W-1:0]             wdata_i,
  input wire [`AXIL_STRB_W-1:0]             wstrb_i,
  input wire                                arvalid_i,
  input wire                                arready_i,
  input wire [`AXIL_ADDR_W-1:0]             araddr_i,
  input wire                                bvalid_i,
  input wire                                bready_i,
  input wire [1:0]                          bresp_i,
  input wire                                rvalid_i,
  input wire                                rready_i,
  input wire [`AXIL_DATA_W-1:0]             rdata_i,
  input wire [1:0]                          rresp_i,
  input wire                                fwd_v_i,
  input wire                                fwd_ready_and_i,
  input wire axil_mem_pkg::mem_fwd_header_s fwd_header_i
);

  int unsigned fail_cnt = 0;

  aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
  else begin
    fail_cnt++;
    $error("AW valid or address changed before awready");
  end

  w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable({wdata_i, wstrb_i}))
  else begin
    fail_cnt++;
    $error("W valid or payload changed before wready");
  end

  ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
  else begin
    fail_cnt++;
    $error("AR valid or address changed before arready");
  end

  b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
  else begin
    fail_cnt++;
    $error("B valid or response changed before bready");
  end

  r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable({rdata_i, rresp_i}))
  else begin
    fail_cnt++;
    $error("R valid or data changed before rready");
  end

  // One response channel at a time
  b_r_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(bvalid_i && rvalid_i))
  else begin
    fail_cnt++;
    $error("bvalid and rvalid high in the same cycle");
  end

  fwd_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fwd_v_i && !fwd_ready_and_i |=> fwd_v_i && $stable(fwd_header_i))
  else begin
    fail_cnt++;
    $error("Forward message valid or header changed before ready_and");
  end

endmodule

bind axil_mem_top axil_mem_sva u_sva (
  .clk_i           (clk_i),
  .arst_n_i        (arst_n_i),
  .awvalid_i       (s_axil_awvalid_i),
  .awready_i       (s_axil_awready_o),
  .awaddr_i        (s_axil_awaddr_i),
  .wvalid_i        (s_axil_wvalid_i),
  .wready_i        (s_axil_wready_o),
  .wdata_i         (s_axil_wdata_i),
  .wstrb_i         (s_axil_wstrb_i),
  .arvalid_i       (s_axil_arvalid_i),
  .arready_i       (s_axil_arready_o),
  .araddr_i        (s_axil_araddr_i),
  .bvalid_i        (s_axil_bvalid_o),
  .bready_i        (s_axil_bready_i),
  .bresp_i         (s_axil_bresp_o),
  .rvalid_i        (s_axil_rvalid_o),
  .rready_i        (s_axil_rready_i),
  .rdata_i         (s_axil_rdata_o),
  .rresp_i         (s_axil_rresp_o),
  .fwd_v_i         (fwd_if.v),
  .fwd_ready_and_i (fwd_if.ready_and),
  .fwd_header_i    (fwd_if.header)
);

`default_nettype wire

// ==== verif/axil_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_mem_defs.svh"

module axil_mem_tb;

  // Roughly 200 transactions of about 4 cycles, stalls, and a wide margin
  localparam int CYCLE_LIMIT = 4000;
  localparam int MEM_BYTES   = `MEM_WORDS * 4;

  logic                    clk;
  logic                    arst_n;
  logic [`LCE_ID_W-1:0]    lce_id;
  logic [`DID_W-1:0]       did;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [`AXIL_DATA_W-1:0] wdata;
  logic [`AXIL_STRB_W-1:0] wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic                    arvalid;
  logic                    arready;
  logic [`AXIL_DATA_W-1:0] rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;

  logic [7:0]  ref_mem [MEM_BYTES];
  logic [15:0] lfsr;
  int          cycles;
  int          checks;
  int          errors;

  axil_mem_top dut (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .lce_id_i         (lce_id),
    .did_i            (did),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  always #20 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr[0];
      lfsr    = lfsr >> 1;
      if (bit_out) begin
        lfsr = lfsr ^ 16'hB400;
      end
      val = {val[30:0], bit_out};
    end
    return val;
  endfunction

  // Size from the strobe, bytes placed from the addressed lane
  task automatic ref_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int base;
    int first;
    int nbytes;
    base  = int'((addr >> 2) % `MEM_WORDS) * 4;
    first = int'(addr[1:0]);
    case (strb)
      4'h1, 4'h2, 4'h4, 4'h8: nbytes = 1;
      4'h3, 4'hC:             nbytes = 2;
      default: begin
        nbytes = 4;
        first  = 0;
      end
    endcase
    for (int b = first; b < first + nbytes; b++) begin
      ref_mem[base + b] = data[8*b +: 8];
    end
  endtask

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    int base;
    base = int'((addr >> 2) % `MEM_WORDS) * 4;
    return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic print_counts;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut.u_sva.fail_cnt);
  endtask

  // Drive point just after the next rising edge
  task automatic next_drive;
    @(posedge clk);
    #2;
  endtask

  // Expects bready high
  task automatic axil_write(input string name, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_value($sformatf("%s wready", name), 32'd1, 32'(wready));
    next_drive();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_value($sformatf("%s bresp", name), 32'd0, 32'(bresp));
    next_drive();
    ref_write(addr, data, strb);
  endtask

  // Expects rready high
  task automatic axil_read(input string name, input logic [31:0] addr,
                           output logic [31:0] data);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    next_drive();
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    check_value($sformatf("%s rresp", name), 32'd0, 32'(rresp));
    next_drive();
  endtask

  task automatic full_word_roundtrip;
    logic [31:0] got;
    axil_write("full_word", 32'h10, 32'hDEAD_BEEF, 4'hF);
    axil_read("full_word", 32'h10, got);
    check_value("full_word", 32'hDEAD_BEEF, got);
  endtask

  task automatic single_byte_writes;
    logic [31:0] got;
    axil_write("byte_lanes", 32'h20, 32'h1122_3344, 4'hF);
    for (int l = 0; l < 4; l++) begin
      axil_write("byte_lanes", 32'h20 + 32'(l), 32'h0101_0101 * 32'(l + 10),
                 4'(4'b0001 << l));
      axil_read("byte_lanes", 32'h20, got);
      check_value("byte_lanes", ref_read(32'h20), got);
    end
    check_value("byte_lanes final", 32'h0D0C_0B0A, got);
  endtask

  task automatic half_word_writes;
    logic [31:0] got;
    axil_write("half_words", 32'h30, 32'h5566_7788, 4'hF);
    axil_write("half_words", 32'h30, 32'hFFFF_ABCD, 4'h3);
    axil_read("half_words", 32'h30, got);
    check_value("half_words low", 32'h5566_ABCD, got);
    axil_write("half_words", 32'h32, 32'h1234_FFFF, 4'hC);
    axil_read("half_words", 32'h30, got);
    check_value("half_words high", 32'h1234_ABCD, got);
    // Strobe 0x5 is neither a lane nor a half word
    axil_write("half_words", 32'h30, 32'hCAFE_F00D, 4'h5);
    axil_read("half_words", 32'h30, got);
    check_value("half_words odd strobe", 32'hCAFE_F00D, got);
  endtask

  task automatic random_traffic;
    logic [31:0] word;
    logic [31:0] lane;
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] got;
    logic [3:0]  strb;
    // Fill the whole target so no read sees unwritten storage
    for (int i = 0; i < `MEM_WORDS; i++) begin
      axil_write("fill", 32'(i * 4), 32'h9E37_79B9 * 32'(i + 1), 4'hF);
    end
    for (int n = 0; n < 40; n++) begin
      word = rand_bits(10);
      strb = 4'(rand_bits(4));
      data = rand_bits(32);
      // Address points at the first strobed lane
      case (strb)
        4'h2:       lane = 32'd1;
        4'h4, 4'hC: lane = 32'd2;
        4'h8:       lane = 32'd3;
        default:    lane = 32'd0;
      endcase
      addr = (word << 2) | lane;
      axil_write("random", addr, data, strb);
      // Bit 6 of the word index is above the depth, so this aliases
      addr = (word ^ 32'h40) << 2;
      axil_read("random_alias", addr, got);
      check_value("random_alias", ref_read(addr), got);
      addr = rand_bits(10) << 2;
      axil_read("random", addr, got);
      check_value("random", ref_read(addr), got);
    end
  endtask

  task automatic response_stall;
    logic [31:0] held;
    bready  = 1'b0;
    rready  = 1'b0;
    awaddr  = 32'h58;
    wdata   = 32'h0BAD_F00D;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    next_drive();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    ref_write(32'h58, 32'h0BAD_F00D, 4'hF);
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    // Read offered while B is held
    next_drive();
    araddr  = 32'h58;
    arvalid = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("stall_b bvalid", 32'd1, 32'(bvalid));
      check_value("stall_b arready", 32'd0, 32'(arready));
    end
    next_drive();
    bready = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    next_drive();
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    held = rdata;
    check_value("stall_r rdata", ref_read(32'h58), held);
    repeat (4) begin
      @(negedge clk);
      check_value("stall_r rvalid", 32'd1, 32'(rvalid));
      check_value("stall_r stable", held, rdata);
    end
    next_drive();
    rready = 1'b1;
    // R beat taken on this edge, rvalid must drop
    next_drive();
    check_value("stall_r release", 32'd0, 32'(rvalid));
  endtask

  task automatic write_read_race;
    awaddr  = 32'h44;
    wdata   = 32'h600D_CAFE;
    wstrb   = 4'hF;
    araddr  = 32'h44;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_value("race arready", 32'd0, 32'(arready));
    next_drive();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    ref_write(32'h44, 32'h600D_CAFE, 4'hF);
    @(negedge clk);
    while (!bvalid && !rvalid) @(negedge clk);
    check_value("race order", 32'd1, 32'(bvalid));
    next_drive();
    @(negedge clk);
    while (!arready) @(negedge clk);
    next_drive();
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    check_value("race rdata", 32'h600D_CAFE, rdata);
    next_drive();
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: no result after %0d cycles, a handshake never completed", cycles);
    errors++;
    print_counts();
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    clk     = 1'b0;
    arst_n  = 1'b0;
    lce_id  = 4'h5;
    did     = 3'h2;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    lfsr    = 16'd2;
    checks  = 0;
    errors  = 0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    next_drive();

    full_word_roundtrip();
    single_byte_writes();
    half_word_writes();
    random_traffic();
    response_stall();
    write_read_race();

    print_counts();
    if (errors == 0 && dut.u_sva.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/axil_mem_pkg.sv
hdl/mem_msg_if.sv
hdl/axil_fifo_client.sv
hdl/axil_mem_client.sv
hdl/uc_mem_target.sv
hdl/axil_mem_top.sv
verif/axil_mem_sva.sv
verif/axil_mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module axil_mem_tb -f flist.f -o axil_mem_sim

# Keep running past assertion errors so the testbench reaches its verdict
./obj_dir/axil_mem_sim +verilator+error+limit+1000 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed, log in sim.log"
else
  echo "Simulation failed, log in sim.log"
  exit 1
fi
